/* sources.f */
+incdir+test
source/md_pkg.sv
source/force_cache_if.sv
source/state_cache_if.sv
source/force_writeback_arbiter.sv
source/force_cache.sv
source/particle_state_cache.sv
source/step_sync.sv
source/motion_update.sv
source/md_cell_top.sv
test/tb_md_cell.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert
TOP = tb_md_cell
FILELIST = sources.f

BUILD_DIR = obj_dir
SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard source/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_md_checks.svh */
`ifndef TB_MD_CHECKS_SVH
`define TB_MD_CHECKS_SVH

// Running totals for the closing summary
int err_count = 0;
int test_count = 0;

// LCG state for the random rows and the shuffled step order
int unsigned lcg_state = 30;

function automatic int unsigned lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Whole vector compare, shown as one hex word
task automatic check_vec3(input string name, input vec3_t exp_v, input vec3_t got_v);
	if (got_v !== exp_v)
	begin
		$display("mismatch %s exp=%h got=%h", name, exp_v, got_v);
		err_count++;
	end
endtask

// Single bit compare, an X counts as wrong
task automatic check_flag(input string name, input logic exp_b, input logic got_b);
	if (got_b !== exp_b)
	begin
		$display("mismatch %s exp=%h got=%h", name, exp_b, got_b);
		err_count++;
	end
endtask

`endif

/* test/tb_md_cell.sv */
`timescale 1ns/1ps

module tb_md_cell
	import md_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 4;
	localparam int N_FIXED = 13;
	// Two batches of one record per pipeline, then the step
	localparam int ROWS_PER_STEP = 2 * (NUM_PIPELINES + 1) + 1;
	localparam int N_ROWS = N_FIXED + 3 * ROWS_PER_STEP;
	localparam int WAIT_LIMIT = 2 * NUM_SLOTS + 8;
	localparam int WATCHDOG_NS = N_ROWS * (NUM_PIPELINES + 2 * NUM_SLOTS + 10) * 2 * CLK_PERIOD;

	typedef enum logic [1:0] {K_RESET, K_FORCE, K_PUSH, K_STEP} row_kind_e;

	typedef struct {
		row_kind_e kind;
		int pipe;
		slot_addr_t slot;
		vec3_t f;
	} row_t;

	logic clk;
	logic rst;
	pipe_mask_t force_valid;
	force_rec_t force_rec [NUM_PIPELINES];
	pipe_mask_t write_success;
	pipe_mask_t home_cell_done;
	pipe_mask_t local_mu_start;
	logic all_done_reading;
	logic motion_update_done;
	logic pos_rd_en;
	slot_addr_t pos_rd_addr;
	vec3_t pos_rd_data;
	logic pos_rd_valid;

	row_t rows [N_ROWS];
	// Reference model of the cell
	vec3_t m_force [NUM_SLOTS];
	vec3_t m_vel [NUM_SLOTS];
	vec3_t m_pos [NUM_SLOTS];
	// Records collected for the next simultaneous batch
	pipe_mask_t pend_mask;
	force_rec_t pend_rec [NUM_PIPELINES];

	`include "tb_md_checks.svh"

	md_cell_top u_md_cell_top (
		.clk(clk),
		.rst(rst),
		.force_valid(force_valid),
		.force_rec(force_rec),
		.write_success(write_success),
		.home_cell_done(home_cell_done),
		.local_mu_start(local_mu_start),
		.all_done_reading(all_done_reading),
		.motion_update_done(motion_update_done),
		.pos_rd_en(pos_rd_en),
		.pos_rd_addr(pos_rd_addr),
		.pos_rd_data(pos_rd_data),
		.pos_rd_valid(pos_rd_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic vec3_t vec_add(input vec3_t a, input vec3_t b);
		vec3_t s;
		s.x = a.x + b.x;
		s.y = a.y + b.y;
		s.z = a.z + b.z;
		return s;
	endfunction

	// Time step as an arithmetic right shift
	function automatic vec3_t vec_dt(input vec3_t a);
		vec3_t s;
		s.x = a.x >>> DT_SHIFT;
		s.y = a.y >>> DT_SHIFT;
		s.z = a.z >>> DT_SHIFT;
		return s;
	endfunction

	// New velocity first, position moves by the new velocity
	task automatic apply_step();
		for (int i = 0; i < NUM_SLOTS; i++)
		begin
			m_vel[i] = vec_add(m_vel[i], vec_dt(m_force[i]));
			m_pos[i] = vec_add(m_pos[i], vec_dt(m_vel[i]));
			m_force[i] = '0;
		end
	endtask

	task automatic add_row(inout int idx, input row_kind_e kind, input int pipe,
		input int slot, input int fx, input int fy, input int fz);
		rows[idx].kind = kind;
		rows[idx].pipe = pipe;
		rows[idx].slot = slot_addr_t'(slot);
		rows[idx].f.x = coord_t'(fx);
		rows[idx].f.y = coord_t'(fy);
		rows[idx].f.z = coord_t'(fz);
		idx++;
	endtask

	task automatic fill_table();
		int idx;
		idx = 0;
		add_row(idx, K_RESET, 0, 0, 0, 0, 0);
		// All four pipelines at once on separate slots
		add_row(idx, K_FORCE, 0, 1, 400, -200, 36);
		add_row(idx, K_FORCE, 1, 2, -800, 120, 7);
		add_row(idx, K_FORCE, 2, 3, 64, 64, -64);
		add_row(idx, K_FORCE, 3, 4, 1000, -1000, 3);
		add_row(idx, K_PUSH, 0, 0, 0, 0, 0);
		// Four partial forces summed into slot 5
		add_row(idx, K_FORCE, 0, 5, 100, -52, 9);
		add_row(idx, K_FORCE, 1, 5, -30, 300, 17);
		add_row(idx, K_FORCE, 2, 5, 250, 8, -90);
		add_row(idx, K_FORCE, 3, 5, 6, -400, 1);
		add_row(idx, K_PUSH, 0, 0, 0, 0, 0);
		add_row(idx, K_STEP, 0, 0, 0, 0, 0);
		// No new forces, so only the kept velocity moves the particles
		add_row(idx, K_STEP, 0, 0, 0, 0, 0);
		for (int s = 0; s < 3; s++)
		begin
			for (int b = 0; b < 2; b++)
			begin
				for (int p = 0; p < NUM_PIPELINES; p++)
					add_row(idx, K_FORCE, p, lcg_next() % NUM_SLOTS, int'(lcg_next() >> 16),
						int'(lcg_next() >> 16), int'(lcg_next() >> 16));
				add_row(idx, K_PUSH, 0, 0, 0, 0, 0);
			end
			add_row(idx, K_STEP, 0, 0, 0, 0, 0);
		end
	endtask

	// Reads every slot through the outside port
	task automatic check_positions();
		for (int i = 0; i < NUM_SLOTS; i++)
		begin
			@(negedge clk);
			pos_rd_en = 1'b1;
			pos_rd_addr = slot_addr_t'(i);
			@(negedge clk);
			pos_rd_en = 1'b0;
			check_flag("pos_rd_valid", 1'b1, pos_rd_valid);
			check_vec3($sformatf("pos_rd_data[%0d]", i), m_pos[i], pos_rd_data);
		end
	endtask

	task automatic check_reset_state();
		for (int p = 0; p < NUM_PIPELINES; p++)
			check_flag($sformatf("write_success[%0d]", p), 1'b0, write_success[p]);
		check_flag("all_done_reading", 1'b0, all_done_reading);
		check_flag("motion_update_done", 1'b0, motion_update_done);
		check_flag("pos_rd_valid", 1'b0, pos_rd_valid);
		check_positions();
	endtask

	// Presents the pending records together and counts the success pulses
	task automatic push_batch();
		int hits [NUM_PIPELINES];
		int waited;
		pipe_mask_t open_mask;
		pipe_mask_t release_mask;
		for (int p = 0; p < NUM_PIPELINES; p++)
		begin
			hits[p] = 0;
			if (pend_mask[p])
			begin
				force_valid[p] = 1'b1;
				force_rec[p] = pend_rec[p];
			end
		end
		open_mask = pend_mask;
		release_mask = '0;
		waited = 0;
		while (open_mask != '0 && waited <= 2 * NUM_PIPELINES)
		begin
			@(negedge clk);
			waited++;
			// Valid stayed up through the edge that showed the success
			force_valid = force_valid & ~release_mask;
			release_mask = '0;
			for (int p = 0; p < NUM_PIPELINES; p++)
			begin
				if (write_success[p])
					hits[p]++;
				if (write_success[p] && open_mask[p])
				begin
					// Accepted, so the record joins the model
					open_mask[p] = 1'b0;
					release_mask[p] = 1'b1;
					m_force[pend_rec[p].slot] = vec_add(m_force[pend_rec[p].slot],
						pend_rec[p].force_vec);
					if (waited > NUM_PIPELINES)
					begin
						$display("pipeline %0d waited %0d cycles for write success", p, waited);
						err_count++;
					end
				end
			end
		end
		if (open_mask != '0)
		begin
			$display("no write success for pipelines %b after %0d cycles", open_mask, waited);
			err_count++;
			force_valid = '0;
		end
		// Last winner still held valid, a repeated grant would pulse here
		@(negedge clk);
		force_valid = '0;
		for (int p = 0; p < NUM_PIPELINES; p++)
		begin
			if (write_success[p])
				hits[p]++;
			if (hits[p] != (pend_mask[p] ? 1 : 0))
			begin
				$display("pipeline %0d got %0d success pulses for %0d records", p, hits[p],
					pend_mask[p] ? 1 : 0);
				err_count++;
			end
		end
		pend_mask = '0;
	endtask

	// Done flags and start pulses in a shuffled order, pulses spread out
	task automatic run_step();
		int order [NUM_PIPELINES];
		int j;
		int tmp;
		int waited;
		logic done_before;
		for (int i = 0; i < NUM_PIPELINES; i++)
			order[i] = i;
		for (int i = NUM_PIPELINES - 1; i > 0; i--)
		begin
			j = lcg_next() % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < NUM_PIPELINES; i++)
		begin
			home_cell_done[order[i]] = 1'b1;
			@(negedge clk);
			check_flag("all_done_reading", i == NUM_PIPELINES - 1, all_done_reading);
		end
		done_before = motion_update_done;
		for (int i = 0; i < NUM_PIPELINES; i++)
		begin
			repeat (lcg_next() % 4 + 1) @(negedge clk);
			// Update must not start before the last pulse
			check_flag("motion_update_done", done_before, motion_update_done);
			local_mu_start[order[i]] = 1'b1;
			@(negedge clk);
			local_mu_start[order[i]] = 1'b0;
		end
		// Start is high now, done drops one cycle later
		@(negedge clk);
		waited = 1;
		check_flag("motion_update_done", 1'b0, motion_update_done);
		while (!motion_update_done && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!motion_update_done)
		begin
			$display("motion update did not finish within %0d cycles", WAIT_LIMIT);
			err_count++;
		end
		else if (waited != 2 * NUM_SLOTS + 1)
		begin
			$display("motion update took %0d cycles instead of %0d", waited, 2 * NUM_SLOTS + 1);
			err_count++;
		end
		repeat (3) @(negedge clk);
		check_flag("motion_update_done", 1'b1, motion_update_done);
		home_cell_done = '0;
		apply_step();
		check_positions();
	endtask

	initial
	begin
		int errs_before;
		clk = 1'b0;
		rst = 1'b1;
		force_valid = '0;
		home_cell_done = '0;
		local_mu_start = '0;
		pos_rd_en = 1'b0;
		pos_rd_addr = '0;
		pend_mask = '0;
		for (int p = 0; p < NUM_PIPELINES; p++)
		begin
			force_rec[p] = '0;
			pend_rec[p] = '0;
		end
		for (int i = 0; i < NUM_SLOTS; i++)
		begin
			m_force[i] = '0;
			m_vel[i] = '0;
			m_pos[i] = '0;
		end
		fill_table();
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < N_ROWS; i++)
		begin
			errs_before = err_count;
			case (rows[i].kind)
				K_RESET: check_reset_state();
				K_FORCE:
				begin
					pend_mask[rows[i].pipe] = 1'b1;
					pend_rec[rows[i].pipe].slot = rows[i].slot;
					pend_rec[rows[i].pipe].force_vec = rows[i].f;
				end
				K_PUSH: push_batch();
				default: run_step();
			endcase
			test_count++;
			if (err_count == errs_before)
				$display("row %0d %s ok", i, rows[i].kind.name());
			else
				$display("row %0d %s failed", i, rows[i].kind.name());
		end
		$display("rows=%0d errors=%0d", test_count, err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Bound on the whole run, scaled by the table length
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test table finished");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* source/md_cell_top.sv */
`timescale 1ns/1ps

module md_cell_top
	import md_pkg::*;
(
	input logic clk,
	input logic rst,
	// Force records from the pipelines
	input pipe_mask_t force_valid,
	input force_rec_t force_rec [NUM_PIPELINES],
	output pipe_mask_t write_success,
	// Step control
	input pipe_mask_t home_cell_done,
	input pipe_mask_t local_mu_start,
	output logic all_done_reading,
	output logic motion_update_done,
	// Outside position read
	input logic pos_rd_en,
	input slot_addr_t pos_rd_addr,
	output vec3_t pos_rd_data,
	output logic pos_rd_valid
);

	logic mu_start;
	logic mu_busy;

	force_cache_if u_fc_if ();
	state_cache_if u_sc_if ();

	force_writeback_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.force_valid(force_valid),
		.force_rec(force_rec),
		.write_success(write_success),
		.mu_busy(mu_busy),
		.fc(u_fc_if.arbiter)
	);

	force_cache u_force_cache (
		.clk(clk),
		.rst(rst),
		.fc(u_fc_if.cache)
	);

	particle_state_cache u_state_cache (
		.clk(clk),
		.rst(rst),
		.sc(u_sc_if.cache),
		.pos_rd_en(pos_rd_en),
		.pos_rd_addr(pos_rd_addr),
		.pos_rd_data(pos_rd_data),
		.pos_rd_valid(pos_rd_valid)
	);

	step_sync u_step_sync (
		.clk(clk),
		.rst(rst),
		.home_cell_done(home_cell_done),
		.local_mu_start(local_mu_start),
		.all_done_reading(all_done_reading),
		.mu_start(mu_start)
	);

	motion_update u_motion_update (
		.clk(clk),
		.rst(rst),
		.mu_start(mu_start),
		.mu_busy(mu_busy),
		.motion_update_done(motion_update_done),
		.fc(u_fc_if.updater),
		.sc(u_sc_if.updater)
	);

endmodule

/* source/motion_update.sv */
`timescale 1ns/1ps

module motion_update
	import md_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic mu_start,
	output logic mu_busy,
	output logic motion_update_done,
	force_cache_if.updater fc,
	state_cache_if.updater sc
);

	mu_state_e state;
	slot_addr_t slot;
	vec3_t force_dt;
	vec3_t new_vel;
	vec3_t vel_dt;
	vec3_t new_pos;

	// Two cycles per slot, read then write, slots in order
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= MU_IDLE;
			slot <= '0;
		end
		else
		begin
			case (state)
				MU_IDLE, MU_DONE:
				begin
					if (mu_start)
					begin
						state <= MU_READ;
						slot <= '0;
					end
				end
				MU_READ:
				begin
					state <= MU_WRITE;
				end
				MU_WRITE:
				begin
					if (slot == slot_addr_t'(NUM_SLOTS - 1))
						state <= MU_DONE;
					else
					begin
						state <= MU_READ;
						slot <= slot + 1'b1;
					end
				end
				default:
				begin
					state <= MU_IDLE;
				end
			endcase
		end
	end

	// Velocity first, position then uses the new velocity
	// Arithmetic shift keeps the sign, sums wrap at 16 bits
	always_comb
	begin
		force_dt.x = fc.rd_force.x >>> DT_SHIFT;
		force_dt.y = fc.rd_force.y >>> DT_SHIFT;
		force_dt.z = fc.rd_force.z >>> DT_SHIFT;
		new_vel.x = sc.rd_vel.x + force_dt.x;
		new_vel.y = sc.rd_vel.y + force_dt.y;
		new_vel.z = sc.rd_vel.z + force_dt.z;
		vel_dt.x = new_vel.x >>> DT_SHIFT;
		vel_dt.y = new_vel.y >>> DT_SHIFT;
		vel_dt.z = new_vel.z >>> DT_SHIFT;
		new_pos.x = sc.rd_pos.x + vel_dt.x;
		new_pos.y = sc.rd_pos.y + vel_dt.y;
		new_pos.z = sc.rd_pos.z + vel_dt.z;
	end

	assign mu_busy = (state == MU_READ) || (state == MU_WRITE);
	// Held until the next start
	assign motion_update_done = (state == MU_DONE);

	// Force read also clears the slot
	assign fc.rd_en = (state == MU_READ);
	assign fc.rd_addr = slot;
	assign sc.rd_addr = slot;

	// Cache data from the read cycle is on hand in the write cycle
	assign sc.wr_en = (state == MU_WRITE);
	assign sc.wr_addr = slot;
	assign sc.wr_pos = new_pos;
	assign sc.wr_vel = new_vel;

	// Step sync must not restart a running update
	a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
		mu_start |-> !mu_busy)
		else $error("motion update start while the update is running");

endmodule

/* source/step_sync.sv */
`timescale 1ns/1ps

module step_sync
	import md_pkg::*;
(
	input logic clk,
	input logic rst,
	input pipe_mask_t home_cell_done,
	input pipe_mask_t local_mu_start,
	output logic all_done_reading,
	output logic mu_start
);

	// One bit per pipeline, set by its start pulse
	pipe_mask_t history;

	// Every pipeline has finished reading the home cell
	assign all_done_reading = &home_cell_done;

	// Fires in the cycle the last history bit is seen set
	assign mu_start = &history;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			history <= '0;
		end
		else if (mu_start)
		begin
			// Clear first so the start stays a single cycle
			history <= '0;
		end
		else
		begin
			// Pulses may arrive in any order and spread out
			history <= history | local_mu_start;
		end
	end

endmodule

/* source/particle_state_cache.sv */
`timescale 1ns/1ps

module particle_state_cache
	import md_pkg::*;
(
	input logic clk,
	input logic rst,
	state_cache_if.cache sc,
	input logic pos_rd_en,
	input slot_addr_t pos_rd_addr,
	output vec3_t pos_rd_data,
	output logic pos_rd_valid
);

	vec3_t pos_mem [NUM_SLOTS];
	vec3_t vel_mem [NUM_SLOTS];

	// Storage, single write port from the updater
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_SLOTS; i++)
			begin
				pos_mem[i] <= '0;
				vel_mem[i] <= '0;
			end
		end
		else if (sc.wr_en)
		begin
			pos_mem[sc.wr_addr] <= sc.wr_pos;
			vel_mem[sc.wr_addr] <= sc.wr_vel;
		end
	end

	// Updater read port, always reading
	// Returns the old value on a same-cycle write
	always_ff @(posedge clk)
	begin
		sc.rd_pos <= pos_mem[sc.rd_addr];
		sc.rd_vel <= vel_mem[sc.rd_addr];
	end

	// Outside position read, usable at any time
	always_ff @(posedge clk)
	begin
		if (rst)
			pos_rd_valid <= 1'b0;
		else
			pos_rd_valid <= pos_rd_en;
		if (pos_rd_en)
			pos_rd_data <= pos_mem[pos_rd_addr];
	end

endmodule

/* source/force_cache.sv */
`timescale 1ns/1ps

module force_cache
	import md_pkg::*;
(
	input logic clk,
	input logic rst,
	force_cache_if.cache fc
);

	vec3_t mem [NUM_SLOTS];
	vec3_t sum;

	// Component-wise accumulate, wraps at the coordinate width
	always_comb
	begin
		sum.x = mem[fc.wr_addr].x + fc.wr_force.x;
		sum.y = mem[fc.wr_addr].y + fc.wr_force.y;
		sum.z = mem[fc.wr_addr].z + fc.wr_force.z;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_SLOTS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else
		begin
			// Clear on read, so the next step starts from zero
			if (fc.rd_en)
			begin
				mem[fc.rd_addr] <= '0;
			end
			// Write comes second and wins on a shared slot
			if (fc.wr_valid)
			begin
				mem[fc.wr_addr] <= sum;
			end
		end
	end

	// Registered read data for the updater
	always_ff @(posedge clk)
	begin
		if (fc.rd_en)
		begin
			fc.rd_force <= mem[fc.rd_addr];
		end
	end

	// Arbiter and motion update never touch one slot together
	a_no_rd_wr_clash: assert property (@(posedge clk) disable iff (rst)
		(fc.rd_en && fc.wr_valid) |-> (fc.rd_addr != fc.wr_addr))
		else $error("force cache read and write hit the same slot");

endmodule

/* source/force_writeback_arbiter.sv */
`timescale 1ns/1ps

module force_writeback_arbiter
	import md_pkg::*;
(
	input logic clk,
	input logic rst,
	input pipe_mask_t force_valid,
	input force_rec_t force_rec [NUM_PIPELINES],
	output pipe_mask_t write_success,
	input logic mu_busy,
	force_cache_if.arbiter fc
);

	pipe_idx_t last_grant;
	pipe_idx_t grant_idx;
	pipe_idx_t cand;
	pipe_mask_t eligible;
	logic grant_any;

	// A pipeline seeing its success this cycle still holds valid, so skip it
	// Nothing is taken while the slots are being integrated
	always_comb
	begin
		eligible = force_valid & ~write_success & {NUM_PIPELINES{~mu_busy}};
		grant_any = 1'b0;
		grant_idx = last_grant;
		cand = last_grant;
		// Search starts one past the last winner, the winner itself comes last
		for (int k = 1; k <= NUM_PIPELINES; k++)
		begin
			cand = last_grant + pipe_idx_t'(k);
			if (!grant_any && eligible[cand])
			begin
				grant_any = 1'b1;
				grant_idx = cand;
			end
		end
	end

	// Success pulse and cache write land in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			write_success <= '0;
			fc.wr_valid <= 1'b0;
			// Pipeline 0 has first priority after reset
			last_grant <= pipe_idx_t'(NUM_PIPELINES - 1);
		end
		else
		begin
			write_success <= '0;
			fc.wr_valid <= grant_any;
			if (grant_any)
			begin
				write_success[grant_idx] <= 1'b1;
				last_grant <= grant_idx;
			end
		end
	end

	// Winner's record
	always_ff @(posedge clk)
	begin
		if (grant_any)
		begin
			fc.wr_addr <= force_rec[grant_idx].slot;
			fc.wr_force <= force_rec[grant_idx].force_vec;
		end
	end

	// Pipelines must be drained before the motion update starts
	a_no_force_during_mu: assert property (@(posedge clk) disable iff (rst)
		mu_busy |-> !(|force_valid))
		else $error("force record presented while motion update is running");

endmodule

/* source/state_cache_if.sv */
`timescale 1ns/1ps

interface state_cache_if
	import md_pkg::*;
();

	// Registered read, data one cycle after the address
	slot_addr_t rd_addr;
	vec3_t rd_pos;
	vec3_t rd_vel;

	// Write back of the integrated state
	logic wr_en;
	slot_addr_t wr_addr;
	vec3_t wr_pos;
	vec3_t wr_vel;

	modport updater (
		output rd_addr, output wr_en, output wr_addr, output wr_pos, output wr_vel,
		input rd_pos, input rd_vel
	);

	modport cache (
		input rd_addr, input wr_en, input wr_addr, input wr_pos, input wr_vel,
		output rd_pos, output rd_vel
	);

endinterface

/* source/force_cache_if.sv */
`timescale 1ns/1ps

interface force_cache_if
	import md_pkg::*;
();

	// Accumulate port, one record per cycle from the arbiter
	logic wr_valid;
	slot_addr_t wr_addr;
	vec3_t wr_force;

	// Read and clear port for the motion update
	logic rd_en;
	slot_addr_t rd_addr;
	// Valid one cycle after rd_en
	vec3_t rd_force;

	modport arbiter (output wr_valid, output wr_addr, output wr_force);

	modport updater (output rd_en, output rd_addr, input rd_force);

	modport cache (
		input wr_valid, input wr_addr, input wr_force,
		input rd_en, input rd_addr, output rd_force
	);

endinterface

/* source/md_pkg.sv */
package md_pkg;

	// Home cell sizes
	localparam int NUM_PIPELINES = 4;
	localparam int NUM_SLOTS = 16;

	// Signed fixed point, one component
	localparam int COORD_WIDTH = 16;

	// Time step as a right shift, shared by the velocity and position update
	localparam int DT_SHIFT = 2;

	typedef logic [$clog2(NUM_SLOTS)-1:0] slot_addr_t;
	typedef logic [$clog2(NUM_PIPELINES)-1:0] pipe_idx_t;
	typedef logic [NUM_PIPELINES-1:0] pipe_mask_t;
	typedef logic signed [COORD_WIDTH-1:0] coord_t;

	// Used for force, velocity and position alike
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vec3_t;

	// One partial force for one particle slot
	typedef struct packed {
		slot_addr_t slot;
		vec3_t force_vec;
	} force_rec_t;

	typedef enum logic [1:0] {
		MU_IDLE,
		MU_READ,
		MU_WRITE,
		MU_DONE
	} mu_state_e;

endpackage
